/* list.f */
+incdir+design
design/bp_table_pkg.sv
design/bp_core_pkg.sv
design/bp_weight_ram.sv
design/perceptron_dot.sv
design/perceptron_train.sv
design/perceptron.sv
design/branch_history.sv
design/bp_top.sv
dv/bp_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := bp_tb
FILELIST  := list.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/bp_tb.sv */
//****************************************
// model mirrors table, valid flags and history
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_tb;
    import bp_core_pkg::*;
    import bp_table_pkg::*;

    localparam int ROWS = 2 ** `BP_HASH_WIDTH;
    localparam int TRAIN_ROUNDS = 24;
    localparam int RANDOM_OPS = 300;
    localparam int RUN_CYCLES = 20 + TRAIN_ROUNDS * 5 + 30 + RANDOM_OPS;
    localparam logic [`BP_PC_WIDTH-1:0] PC_MASK = 32'h0000_0f3c;

    logic clk;
    logic rst_n;
    pred_req_t pred_req;
    upd_req_t upd_req;
    pred_rsp_t pred_rsp;

    table_row_t ref_mem [ROWS];
    logic [ROWS-1:0] ref_valid;
    logic [`BP_H_WIDTH-1:0] ref_hist;
    pred_rsp_t exp_q[$];
    pred_rsp_t last_rsp;
    logic rsp_due;
    int seed = 58;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    bp_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pred_req (pred_req),
        .upd_req  (upd_req),
        .pred_rsp (pred_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((RUN_CYCLES + 200) * 20);
        $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES + 200);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [`BP_HASH_WIDTH-1:0] row_index(
        input logic [`BP_PC_WIDTH-1:0] pc,
        input logic [`BP_H_WIDTH-1:0]  hist
    );
        return pc[9:2] ^ hist[7:0] ^ hist[15:8];
    endfunction

    // expected response from the model state at the request edge
    function automatic pred_rsp_t predict(input logic [`BP_PC_WIDTH-1:0] pc);
        pred_rsp_t r;
        logic [`BP_HASH_WIDTH-1:0] idx;
        int sum;
        idx = row_index(pc, ref_hist);
        r = '0;
        r.valid = 1'b1;
        r.hist = ref_hist;
        r.hit = ref_valid[idx] && (ref_mem[idx].tag == pc[31:8]);
        if (r.hit) begin
            r.weights = ref_mem[idx].weights;
            sum = `BP_THRESHOLD;
            for (int k = 0; k < `BP_H_WIDTH; k++) begin
                sum = ref_hist[k] ? sum + int'($signed(r.weights[k]))
                                  : sum - int'($signed(r.weights[k]));
            end
            r.taken = (sum >= 0);
        end
        return r;
    endfunction

    task automatic model_update(input upd_req_t u);
        logic [`BP_HASH_WIDTH-1:0] idx;
        int w;
        idx = row_index(u.pc, u.hist);
        for (int k = 0; k < `BP_H_WIDTH; k++) begin
            w = int'($signed(u.weights[k]));
            if (u.taken == u.hist[k]) begin
                w = (w < 3) ? w + 1 : 3;
            end else begin
                w = (w > -4) ? w - 1 : -4;
            end
            ref_mem[idx].weights[k] = weight_t'(w);
        end
        ref_mem[idx].tag = u.pc[31:8];
        ref_valid[idx] = 1'b1;
        ref_hist = {ref_hist[`BP_H_WIDTH-2:0], u.taken};
    endtask

    // the core hands back what the predictor would return now
    function automatic upd_req_t make_update(input logic [`BP_PC_WIDTH-1:0] pc, input logic t);
        upd_req_t u;
        pred_rsp_t r;
        r = predict(pc);
        u.valid = 1'b1;
        u.pc = pc;
        u.taken = t;
        u.weights = r.weights;
        u.hist = r.hist;
        return u;
    endfunction

    task automatic check_rsp(input pred_rsp_t got, input pred_rsp_t exp);
        if (got.valid !== exp.valid || got.hit !== exp.hit || got.taken !== exp.taken
                || got.hist !== exp.hist) begin
            errors++;
            $display("error at %0t: hit %0b taken %0b hist %h, expected hit %0b taken %0b hist %h",
                     $time, got.hit, got.taken, got.hist, exp.hit, exp.taken, exp.hist);
        end
    endtask

    task automatic check_weights(input weight_vec_t got, input weight_vec_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: weights %h, expected %h", $time, got, exp);
        end
    endtask

    // a request taken at an edge is answered right after that edge
    always @(posedge clk) begin
        rsp_due <= rst_n && pred_req.valid;
    end

    always @(negedge clk) begin
        if (rst_n && pred_rsp.valid !== rsp_due) begin
            errors++;
            $display("error at %0t: response valid %0b, expected %0b",
                     $time, pred_rsp.valid, rsp_due);
        end
        if (rst_n && pred_rsp.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at %0t arrived with no request pending", $time);
            end else begin
                check_rsp(pred_rsp, exp_q[0]);
                check_weights(pred_rsp.weights, exp_q[0].weights);
                void'(exp_q.pop_front());
            end
            last_rsp = pred_rsp;
        end
    end

    // prediction is modeled before the same edge's update
    task automatic drive_cycle(input pred_req_t p, input upd_req_t u);
        if (p.valid) begin
            exp_q.push_back(predict(p.pc));
        end
        if (u.valid) begin
            model_update(u);
        end
        pred_req <= p;
        upd_req <= u;
        @(posedge clk);
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            drive_cycle('0, '0);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived by %0t", exp_q.size(), $time);
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        wait_responses();
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    endtask

    initial begin
        pred_req_t p;
        upd_req_t u;
        logic [31:0] r;
        logic [`BP_PC_WIDTH-1:0] train_pc;
        pred_rsp_t exp_rsp;
        weight_vec_t sat;
        int model_flip;
        int dut_flip;
        int err_before;

        rst_n = 1'b0;
        pred_req = '0;
        upd_req = '0;
        ref_valid = '0;
        ref_hist = '0;
        train_pc = 32'h0040_1a68;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        err_before = errors;
        p = '0;
        p.valid = 1'b1;
        for (int i = 0; i < 4; i++) begin
            p.pc = $random(seed);
            drive_cycle(p, '0);
        end
        finish_test("miss after reset", err_before);

        err_before = errors;
        model_flip = -1;
        dut_flip = -1;
        p.pc = train_pc;
        for (int i = 0; i < TRAIN_ROUNDS; i++) begin
            exp_rsp = predict(train_pc);
            if (exp_rsp.taken && model_flip < 0) begin
                model_flip = i;
            end
            drive_cycle(p, '0);
            wait_responses();
            if (last_rsp.taken && dut_flip < 0) begin
                dut_flip = i;
            end
            drive_cycle('0, make_update(train_pc, 1'b1));
        end
        if (model_flip < 0 || dut_flip != model_flip) begin
            errors++;
            $display("error at %0t: taken after %0d updates, expected after %0d",
                     $time, dut_flip, model_flip);
        end
        drive_cycle(p, '0);
        wait_responses();
        for (int k = 0; k < `BP_H_WIDTH; k++) begin
            sat[k] = ref_hist[k] ? weight_t'(3) : weight_t'(-4);
        end
        check_weights(last_rsp.weights, sat);
        finish_test("training and saturation", err_before);

        // pc bit 12 is tag only, so the row index stays the same
        err_before = errors;
        p.pc = train_pc ^ 32'h0000_1000;
        drive_cycle(p, '0);
        finish_test("tag mismatch", err_before);

        err_before = errors;
        p.pc = train_pc;
        u = make_update(train_pc, 1'b0);
        drive_cycle(p, u);
        p.pc[9:2] = row_index(train_pc, u.hist) ^ ref_hist[7:0] ^ ref_hist[15:8];
        drive_cycle(p, '0);
        finish_test("read during write", err_before);

        err_before = errors;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = $random(seed);
            p.valid = r[0];
            p.pc = $random(seed) & PC_MASK;
            u = '0;
            if (r[1]) begin
                u = make_update($random(seed) & PC_MASK, r[2]);
            end
            drive_cycle(p, u);
        end
        finish_test("random mix", err_before);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* design/bp_top.sv */
//****************************************
// no back-pressure, one request per cycle
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bp_core_pkg::pred_req_t  pred_req,
    input  bp_core_pkg::upd_req_t   upd_req,
    output bp_core_pkg::pred_rsp_t  pred_rsp
);
    logic                       rd_en;
    logic [`BP_HASH_WIDTH-1:0]  rd_index;
    logic [`BP_TAG_WIDTH-1:0]   rd_tag;
    logic [`BP_H_WIDTH-1:0]     rd_hist;
    logic [`BP_HASH_WIDTH-1:0]  upd_index;

    branch_history u_history (
        .clk       (clk),
        .rst_n     (rst_n),
        .pred_req  (pred_req),
        .upd_req   (upd_req),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_tag    (rd_tag),
        .rd_hist   (rd_hist),
        .upd_index (upd_index)
    );

    perceptron u_perceptron (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_tag    (rd_tag),
        .rd_hist   (rd_hist),
        .pred_rsp  (pred_rsp),
        .upd_req   (upd_req),
        .upd_index (upd_index)
    );

endmodule

/* design/branch_history.sv */
//****************************************
// non-speculative history, shifts on update
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module branch_history (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bp_core_pkg::pred_req_t      pred_req,
    input  bp_core_pkg::upd_req_t       upd_req,
    output logic                        rd_en,
    output logic [`BP_HASH_WIDTH-1:0]   rd_index,
    output logic [`BP_TAG_WIDTH-1:0]    rd_tag,
    output logic [`BP_H_WIDTH-1:0]      rd_hist,
    output logic [`BP_HASH_WIDTH-1:0]   upd_index
);
    logic [`BP_H_WIDTH-1:0] ghist;

    // word aligned pc bits folded with both history halves
    function automatic logic [`BP_HASH_WIDTH-1:0] hash_index(
        input logic [`BP_PC_WIDTH-1:0] pc,
        input logic [`BP_H_WIDTH-1:0]  hist
    );
        return pc[`BP_HASH_WIDTH+1:2]
            ^ hist[`BP_HASH_WIDTH-1:0]
            ^ hist[`BP_H_WIDTH-1:`BP_HASH_WIDTH];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghist <= '0;
        end else if (upd_req.valid) begin
            ghist <= {ghist[`BP_H_WIDTH-2:0], upd_req.taken};
        end
    end

    assign rd_en    = pred_req.valid;
    assign rd_index = hash_index(pred_req.pc, ghist);
    assign rd_tag   = pred_req.pc[`BP_PC_WIDTH-1 -: `BP_TAG_WIDTH];
    assign rd_hist  = ghist;

    // update path rehashes with the history the prediction used
    assign upd_index = hash_index(upd_req.pc, upd_req.hist);

endmodule

/* design/perceptron.sv */
//****************************************
// response one cycle after the read strobe
// misses give not taken and zero weights
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module perceptron (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_en,
    input  logic [`BP_HASH_WIDTH-1:0]   rd_index,
    input  logic [`BP_TAG_WIDTH-1:0]    rd_tag,
    input  logic [`BP_H_WIDTH-1:0]      rd_hist,
    output bp_core_pkg::pred_rsp_t      pred_rsp,
    input  bp_core_pkg::upd_req_t       upd_req,
    input  logic [`BP_HASH_WIDTH-1:0]   upd_index
);
    import bp_table_pkg::*;

    localparam int ROWS = 2 ** `BP_HASH_WIDTH;

    table_row_t                 rd_row;
    table_row_t                 wr_row;
    weight_vec_t                trained;
    logic                       dot_taken;
    logic                       hit;

    logic [ROWS-1:0]            row_valid;
    logic                       rsp_valid_q;
    logic                       row_valid_q;
    logic [`BP_TAG_WIDTH-1:0]   tag_q;
    logic [`BP_H_WIDTH-1:0]     hist_q;

    bp_weight_ram u_ram (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (rd_index),
        .rd_data (rd_row),
        .wr_en   (upd_req.valid),
        .wr_addr (upd_index),
        .wr_data (wr_row)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            row_valid   <= '0;
        end else begin
            rsp_valid_q <= rd_en;
            if (upd_req.valid) begin
                row_valid[upd_index] <= 1'b1;
            end
        end
    end

    // request side fields travel with the ram read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            row_valid_q <= row_valid[rd_index];
            tag_q       <= rd_tag;
            hist_q      <= rd_hist;
        end
    end

    assign hit = row_valid_q && (rd_row.tag == tag_q);

    perceptron_dot u_dot (
        .weights (rd_row.weights),
        .hist    (hist_q),
        .taken   (dot_taken)
    );

    perceptron_train u_train (
        .weights     (upd_req.weights),
        .hist        (upd_req.hist),
        .taken       (upd_req.taken),
        .new_weights (trained)
    );

    always_comb begin
        wr_row.weights = trained;
        wr_row.tag     = upd_req.pc[`BP_PC_WIDTH-1 -: `BP_TAG_WIDTH];
    end

    always_comb begin
        pred_rsp.valid   = rsp_valid_q;
        pred_rsp.hit     = hit;
        pred_rsp.taken   = hit & dot_taken;
        pred_rsp.weights = hit ? rd_row.weights : '0;
        pred_rsp.hist    = hist_q;
    end

endmodule

/* design/perceptron_train.sv */
//****************************************
// one saturating step per weight
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module perceptron_train (
    input  bp_table_pkg::weight_vec_t   weights,
    input  logic [`BP_H_WIDTH-1:0]      hist,
    input  logic                        taken,
    output bp_table_pkg::weight_vec_t   new_weights
);
    import bp_table_pkg::*;

    localparam weight_t W_MAX = weight_t'({1'b0, {(`BP_WEIGHT_WIDTH-1){1'b1}}});
    localparam weight_t W_MIN = weight_t'({1'b1, {(`BP_WEIGHT_WIDTH-1){1'b0}}});

    always_comb begin
        train_dir_e dir;

        for (int k = 0; k < `BP_H_WIDTH; k++) begin
            // outcome agreeing with history bit k strengthens weight k
            dir = (taken == hist[k]) ? step_up : step_down;
            new_weights[k] = weights[k];
            case (dir)
                step_up: begin
                    if (weights[k] != W_MAX) begin
                        new_weights[k] = weights[k] + 1'b1;
                    end
                end
                step_down: begin
                    if (weights[k] != W_MIN) begin
                        new_weights[k] = weights[k] - 1'b1;
                    end
                end
                default: begin
                    new_weights[k] = weights[k];
                end
            endcase
        end
    end

endmodule

/* design/perceptron_dot.sv */
//****************************************
// combinational, sum width must hold 4*H
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module perceptron_dot (
    input  bp_table_pkg::weight_vec_t   weights,
    input  logic [`BP_H_WIDTH-1:0]      hist,
    output logic                        taken
);
    typedef logic signed [`BP_SUM_WIDTH-1:0] sum_t;

    localparam int NODES = 2 * `BP_H_WIDTH - 1;
    localparam int LEAF0 = `BP_H_WIDTH - 1;

    // heap ordered tree, node i = node 2i+1 + node 2i+2
    sum_t node [NODES];
    sum_t total;

    always_comb begin
        for (int k = 0; k < `BP_H_WIDTH; k++) begin
            // a clear history bit subtracts the weight
            if (hist[k]) begin
                node[LEAF0 + k] = sum_t'($signed(weights[k]));
            end else begin
                node[LEAF0 + k] = -sum_t'($signed(weights[k]));
            end
        end
        for (int i = LEAF0 - 1; i >= 0; i--) begin
            node[i] = node[2*i + 1] + node[2*i + 2];
        end
        total = node[0] + sum_t'(`BP_THRESHOLD);
    end

    // non-negative total predicts taken
    assign taken = ~total[`BP_SUM_WIDTH-1];

endmodule

/* design/bp_weight_ram.sv */
//****************************************
// 1r1w table, read returns the old row
//****************************************
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_weight_ram (
    input  logic                        clk,
    input  logic                        rd_en,
    input  logic [`BP_HASH_WIDTH-1:0]   rd_addr,
    output bp_table_pkg::table_row_t    rd_data,
    input  logic                        wr_en,
    input  logic [`BP_HASH_WIDTH-1:0]   wr_addr,
    input  bp_table_pkg::table_row_t    wr_data
);
    import bp_table_pkg::*;

    localparam int ROWS = 2 ** `BP_HASH_WIDTH;

    table_row_t mem [ROWS];

    // read and write share one edge, so a colliding read sees the old row
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

/* design/bp_core_pkg.sv */
//****************************************
// core facing request and response types
//****************************************
`include "bp_consts.svh"

package bp_core_pkg;

    typedef struct packed {
        logic                     valid;
        logic [`BP_PC_WIDTH-1:0]  pc;
    } pred_req_t;

    // weights and hist go back to the core for training
    typedef struct packed {
        logic                       valid;
        logic                       taken;
        logic                       hit;
        bp_table_pkg::weight_vec_t  weights;
        logic [`BP_H_WIDTH-1:0]     hist;
    } pred_rsp_t;

    // weights and hist as returned in pred_rsp_t
    typedef struct packed {
        logic                       valid;
        logic [`BP_PC_WIDTH-1:0]    pc;
        logic                       taken;
        bp_table_pkg::weight_vec_t  weights;
        logic [`BP_H_WIDTH-1:0]     hist;
    } upd_req_t;

endpackage

/* design/bp_table_pkg.sv */
//****************************************
// table row and training types
//****************************************
`include "bp_consts.svh"

package bp_table_pkg;

    typedef logic signed [`BP_WEIGHT_WIDTH-1:0] weight_t;

    // element k pairs with history bit k
    typedef weight_t [`BP_H_WIDTH-1:0] weight_vec_t;

    typedef struct packed {
        weight_vec_t               weights;
        logic [`BP_TAG_WIDTH-1:0]  tag;
    } table_row_t;

    typedef enum logic {
        step_up,
        step_down
    } train_dir_e;

endpackage

/* design/bp_consts.svh */
//****************************************
// sizes for the perceptron predictor
// history must be twice the index width
//****************************************
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

`define BP_PC_WIDTH     32
`define BP_HASH_WIDTH   8
`define BP_H_WIDTH      16

// two's complement, range -4 to 3
`define BP_WEIGHT_WIDTH 3

`define BP_TAG_WIDTH    24
`define BP_SUM_WIDTH    8
`define BP_THRESHOLD    2

`endif
